// File: design/xdomain_pkg.sv
//**********************************************************
// shared types and sizes for the clka/clkb crossing bridge
// command and response payloads, sample width, FIFO depth
//**********************************************************

package xdomain_pkg;

  // command and response field widths
  localparam int ADDR_W   = 8;
  localparam int WORD_W   = 16;
  localparam int STATUS_W = 4;

  localparam int SAMPLE_W   = 16;  // sample stream word
  localparam int FIFO_AW    = 3;   // 8 entry sample FIFO
  localparam int SYNC_DEPTH = 2;   // flops per synchronizer chain

  // controller to peripheral, 24 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
  } cmd_t;

  // peripheral to controller, 20 bits
  typedef struct packed {
    logic [WORD_W-1:0]   rdata;
    logic [STATUS_W-1:0] status;
  } rsp_t;

endpackage

// File: design/reset_sync.sv
//**********************************************************
// reset synchronizer for one clock domain
// asserts at once, releases on the domain clock
//**********************************************************

`timescale 1ns/10ps

module reset_sync (
  input  logic clk,
  input  logic arst_n,  // raw board reset
  output logic rst_n    // released in step with clk
);

  localparam int SD = xdomain_pkg::SYNC_DEPTH;

  logic [SD-1:0] chain;  // ones shift in after release

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      chain <= '0;
    end else begin
      chain <= {chain[SD-2:0], 1'b1};
    end
  end

  assign rst_n = chain[SD-1];  // last stage only

endmodule

// File: design/handshake_stretch.sv
//**********************************************************
// guaranteed valid/ready crossing between two clocks
// the handshake is stretched as levels across the boundary
//**********************************************************

`timescale 1ns/10ps

module handshake_stretch #(
  parameter type payload_t = logic [7:0]
) (
  // source domain
  input  logic     src_clk,
  input  logic     src_rst_n,
  input  payload_t src_data,
  input  logic     src_valid,
  output logic     src_ready,
  // destination domain
  input  logic     dst_clk,
  input  logic     dst_rst_n,
  output payload_t dst_data,
  output logic     dst_valid,
  input  logic     dst_ready
);

  localparam int SD = xdomain_pkg::SYNC_DEPTH;

  // source side state
  payload_t      a_data;   // held stable for the whole crossing
  logic          a_valid;  // stretched valid level
  logic          a_ready;  // synced ack, one extra cycle
  logic [SD-1:0] x_ack;    // sink taken level into src_clk
  logic          a_load;   // new item accepted

  // destination side state
  logic [SD-1:0] x_valid;     // a_valid into dst_clk
  logic          b_valid;     // crossed valid, one stage later
  payload_t      b_data;
  logic          valid_mask;  // low once the item has been taken

  // only start an item when the previous ack has fully dropped
  assign a_load    = src_valid & ~a_valid & ~a_ready & ~x_ack[SD-1];
  assign src_ready = a_ready;

  always_ff @(posedge src_clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      x_ack   <= '0;
      a_ready <= 1'b0;
      a_valid <= 1'b0;
    end else begin
      x_ack   <= {x_ack[SD-2:0], ~valid_mask};
      a_ready <= x_ack[SD-1];  // delayed so a short pulse is never missed
      if (a_load) begin
        a_valid <= 1'b1;
      end else if (~src_valid & x_ack[SD-1]) begin
        // source let go and the sink has seen it
        a_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge src_clk) begin
    if (a_load) begin
      a_data <= src_data;  // capture with the valid level
    end
  end

  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      x_valid    <= '0;
      b_valid    <= 1'b0;
      valid_mask <= 1'b1;
    end else begin
      x_valid <= {x_valid[SD-2:0], a_valid};
      b_valid <= x_valid[SD-1];
      if (dst_valid & dst_ready) begin
        valid_mask <= 1'b0;  // one transfer per item
      end else if (b_valid & ~x_valid[SD-1]) begin
        valid_mask <= 1'b1;  // crossed valid fell, arm for next item
      end
    end
  end

  // a_data has been still for SD dst cycles by the time the synced valid rises
  always_ff @(posedge dst_clk) begin
    if (x_valid[SD-1] & ~b_valid) begin
      b_data <= a_data;
    end
  end

  assign dst_valid = b_valid & valid_mask;
  assign dst_data  = b_data;

endmodule

// File: design/async_fifo.sv
//**********************************************************
// two-clock FIFO with Gray-coded pointers
// read data shows the head word without a read strobe
//**********************************************************

`timescale 1ns/10ps

module async_fifo #(
  parameter type payload_t = logic [7:0]
) (
  // write domain
  input  logic     wr_clk,
  input  logic     wr_rst_n,
  input  logic     we,
  input  payload_t din,
  output logic     full,
  // read domain
  input  logic     rd_clk,
  input  logic     rd_rst_n,
  input  logic     re,
  output payload_t dout,
  output logic     empty
);

  localparam int AW    = xdomain_pkg::FIFO_AW;
  localparam int SD    = xdomain_pkg::SYNC_DEPTH;
  localparam int DEPTH = 1 << AW;

  payload_t mem [0:DEPTH-1];

  // write pointer, one wrap bit above the address
  logic [AW:0] wbin;
  logic [AW:0] wgray;
  logic [AW:0] wbin_nxt;
  logic        wr_fire;

  // read pointer
  logic [AW:0] rbin;
  logic [AW:0] rgray;
  logic [AW:0] rbin_nxt;
  logic        rd_fire;

  // far Gray pointers, oldest stage last
  logic [SD-1:0][AW:0] rq_sync;  // read ptr in wr_clk
  logic [SD-1:0][AW:0] wq_sync;  // write ptr in rd_clk

  function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
    return b ^ (b >> 1);
  endfunction

  assign wr_fire  = we & ~full;  // writes while full are dropped
  assign rd_fire  = re & ~empty;
  assign wbin_nxt = wbin + 1'b1;
  assign rbin_nxt = rbin + 1'b1;

  // write side
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wbin    <= '0;
      wgray   <= '0;
      rq_sync <= '0;
    end else begin
      rq_sync <= {rq_sync[SD-2:0], rgray};
      if (wr_fire) begin
        wbin  <= wbin_nxt;
        wgray <= bin2gray(wbin_nxt);
      end
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_fire) begin
      mem[wbin[AW-1:0]] <= din;
    end
  end

  // full when writer is a whole lap ahead
  // top two Gray bits differ, the rest match
  assign full = (wgray == {~rq_sync[SD-1][AW:AW-1], rq_sync[SD-1][AW-2:0]});

  // read side
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rbin    <= '0;
      rgray   <= '0;
      wq_sync <= '0;
    end else begin
      wq_sync <= {wq_sync[SD-2:0], wgray};
      if (rd_fire) begin
        rbin  <= rbin_nxt;
        rgray <= bin2gray(rbin_nxt);
      end
    end
  end

  assign empty = (rgray == wq_sync[SD-1]);  // same lap, same slot
  assign dout  = mem[rbin[AW-1:0]];         // head word, show-ahead

endmodule

// File: design/fifo_xdomain.sv
//**********************************************************
// best-effort sample crossing through a two-clock FIFO
// one word per rising edge of wr_valid, read under rd_en
//**********************************************************

`timescale 1ns/10ps

module fifo_xdomain (
  // write domain
  input  logic                              wr_clk,
  input  logic                              wr_rst_n,
  input  logic [xdomain_pkg::SAMPLE_W-1:0]  wr_data,
  input  logic                              wr_valid,
  output logic                              wr_ready,
  // read domain
  input  logic                              rd_clk,
  input  logic                              rd_rst_n,
  input  logic                              rd_en,
  output logic [xdomain_pkg::SAMPLE_W-1:0]  rd_data,
  output logic                              rd_valid,
  input  logic                              rd_ready
);

  typedef logic [xdomain_pkg::SAMPLE_W-1:0] sample_t;

  logic    wr_valid_q;  // previous wr_valid
  logic    wr_stb;      // rising edge of wr_valid
  logic    full;
  logic    empty;
  logic    rd_load;     // pop head into the output register
  sample_t next_data;   // FIFO head

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= wr_valid;
    end
  end

  assign wr_stb   = wr_valid & ~wr_valid_q;
  assign wr_ready = ~full;

  // head is already on dout, no wait after the pop
  assign rd_load = ~empty & rd_en & ~rd_valid;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_valid <= 1'b0;
    end else if (rd_load) begin
      rd_valid <= 1'b1;
    end else if (rd_valid & rd_ready) begin
      rd_valid <= 1'b0;  // word taken
    end
  end

  always_ff @(posedge rd_clk) begin
    if (rd_load) begin
      rd_data <= next_data;
    end
  end

  async_fifo #(
    .payload_t (sample_t)
  ) fifo0 (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .we       (wr_stb),
    .din      (wr_data),
    .full     (full),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .re       (rd_load),  // pop in the load cycle
    .dout     (next_data),
    .empty    (empty)
  );

endmodule

// File: design/xdomain_bridge.sv
//**********************************************************
// clka/clkb bridge with command, response and sample paths
// commands and responses are guaranteed, samples best-effort
//**********************************************************

`timescale 1ns/10ps

module xdomain_bridge (
  input  logic                              clka,
  input  logic                              clkb,
  input  logic                              arst_n,
  // command, clka to clkb
  input  xdomain_pkg::cmd_t                 cmd_data_a,
  input  logic                              cmd_valid_a,
  output logic                              cmd_ready_a,
  output xdomain_pkg::cmd_t                 cmd_data_b,
  output logic                              cmd_valid_b,
  input  logic                              cmd_ready_b,
  // response, clkb to clka
  input  xdomain_pkg::rsp_t                 rsp_data_b,
  input  logic                              rsp_valid_b,
  output logic                              rsp_ready_b,
  output xdomain_pkg::rsp_t                 rsp_data_a,
  output logic                              rsp_valid_a,
  input  logic                              rsp_ready_a,
  // sample stream, clka to clkb
  input  logic [xdomain_pkg::SAMPLE_W-1:0]  smp_data_a,
  input  logic                              smp_valid_a,
  output logic                              smp_ready_a,
  input  logic                              smp_en_b,
  output logic [xdomain_pkg::SAMPLE_W-1:0]  smp_data_b,
  output logic                              smp_valid_b,
  input  logic                              smp_ready_b
);

  logic rst_a_n;  // clka domain reset
  logic rst_b_n;  // clkb domain reset

  reset_sync rst_a (
    .clk    (clka),
    .arst_n (arst_n),
    .rst_n  (rst_a_n)
  );

  reset_sync rst_b (
    .clk    (clkb),
    .arst_n (arst_n),
    .rst_n  (rst_b_n)
  );

  // controller to peripheral
  handshake_stretch #(
    .payload_t (xdomain_pkg::cmd_t)
  ) cmd_xing (
    .src_clk   (clka),
    .src_rst_n (rst_a_n),
    .src_data  (cmd_data_a),
    .src_valid (cmd_valid_a),
    .src_ready (cmd_ready_a),
    .dst_clk   (clkb),
    .dst_rst_n (rst_b_n),
    .dst_data  (cmd_data_b),
    .dst_valid (cmd_valid_b),
    .dst_ready (cmd_ready_b)
  );

  // same crossing, clock roles swapped
  handshake_stretch #(
    .payload_t (xdomain_pkg::rsp_t)
  ) rsp_xing (
    .src_clk   (clkb),
    .src_rst_n (rst_b_n),
    .src_data  (rsp_data_b),
    .src_valid (rsp_valid_b),
    .src_ready (rsp_ready_b),
    .dst_clk   (clka),
    .dst_rst_n (rst_a_n),
    .dst_data  (rsp_data_a),
    .dst_valid (rsp_valid_a),
    .dst_ready (rsp_ready_a)
  );

  fifo_xdomain smp_xing (
    .wr_clk   (clka),
    .wr_rst_n (rst_a_n),
    .wr_data  (smp_data_a),
    .wr_valid (smp_valid_a),
    .wr_ready (smp_ready_a),  // low only while FIFO full
    .rd_clk   (clkb),
    .rd_rst_n (rst_b_n),
    .rd_en    (smp_en_b),
    .rd_data  (smp_data_b),
    .rd_valid (smp_valid_b),
    .rd_ready (smp_ready_b)
  );

endmodule

// File: tb/tb_xdomain_bridge.sv
//**********************************************************
// testbench for the clka/clkb bridge with random traffic on
// all three channels checked against one queue per channel
//**********************************************************

`timescale 1ns/10ps

module tb_xdomain_bridge;

  localparam int WAIT_LIMIT  = 3000;  // edges per wait loop
  localparam int W_CMD_RDY   = 0;     // wait selectors
  localparam int W_RSP_RDY   = 1;
  localparam int W_SMP_RDY   = 2;
  localparam int W_SMP_VLD   = 3;
  localparam int W_ALL_DONE  = 4;
  localparam int MODE_RANDOM = 0;     // sample sink modes
  localparam int MODE_HOLD   = 1;     // enabled but never ready
  localparam int MODE_DRAIN  = 2;     // enabled and ready

  logic                             clka;
  logic                             clkb;
  logic                             arst_n;
  xdomain_pkg::cmd_t                cmd_data_a;
  logic                             cmd_valid_a;
  logic                             cmd_ready_a;
  xdomain_pkg::cmd_t                cmd_data_b;
  logic                             cmd_valid_b;
  logic                             cmd_ready_b;
  xdomain_pkg::rsp_t                rsp_data_b;
  logic                             rsp_valid_b;
  logic                             rsp_ready_b;
  xdomain_pkg::rsp_t                rsp_data_a;
  logic                             rsp_valid_a;
  logic                             rsp_ready_a;
  logic [xdomain_pkg::SAMPLE_W-1:0] smp_data_a;
  logic                             smp_valid_a;
  logic                             smp_ready_a;
  logic                             smp_en_b;
  logic [xdomain_pkg::SAMPLE_W-1:0] smp_data_b;
  logic                             smp_valid_b;
  logic                             smp_ready_b;

  logic [15:0]                      lfsr_q = 16'd35936;  // shared random state
  xdomain_pkg::cmd_t                cmd_q[$];  // commands given away and not yet seen
  xdomain_pkg::rsp_t                rsp_q[$];
  logic [xdomain_pkg::SAMPLE_W-1:0] smp_q[$];
  int                               smp_mode = MODE_RANDOM;

  xdomain_bridge dut0 (.*);

  initial begin
    clka = 1'b0;
    forever #20 clka = ~clka;
  end

  initial begin
    clkb = 1'b0;
    forever #29 clkb = ~clkb;  // 58 ns period unrelated to clka
  end

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[30:0], fb};  // one step per bit
    end
    return r;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("error at %0d ns: %s expected %h actual %h",
                         $time, name, expected, actual));
    end
  endtask

  function automatic logic flag_value(input int sel);
    case (sel)
      W_CMD_RDY: return cmd_ready_a;
      W_RSP_RDY: return rsp_ready_b;
      W_SMP_RDY: return smp_ready_a;
      W_SMP_VLD: return smp_valid_b;
      default:   return (cmd_q.size() + rsp_q.size() + smp_q.size()) == 0;
    endcase
  endfunction

  // polls one condition on the chosen clock until it matches level
  task automatic wait_flag(input logic on_clkb, input int sel, input logic level,
                           input string what);
    int edges;
    edges = 0;
    do begin
      if (on_clkb) begin
        @(posedge clkb);
      end else begin
        @(posedge clka);
      end
      edges++;
      if (edges > WAIT_LIMIT) begin
        fail_run($sformatf("timeout after %0d edges waiting for %s", WAIT_LIMIT, what));
      end
    end while (flag_value(sel) !== level);
  endtask

  task automatic send_cmds(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = rand_bits(2);
      repeat (r[1:0]) @(posedge clka);  // random gap
      r = rand_bits(24);
      @(posedge clka);
      cmd_data_a  <= r[23:0];
      cmd_valid_a <= 1'b1;
      cmd_q.push_back(r[23:0]);
      wait_flag(1'b0, W_CMD_RDY, 1'b1, "cmd_ready_a to rise");
      cmd_valid_a <= 1'b0;  // let go and wait for the ack to drop
      wait_flag(1'b0, W_CMD_RDY, 1'b0, "cmd_ready_a to fall");
    end
  endtask

  task automatic send_rsps(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = rand_bits(2);
      repeat (r[1:0]) @(posedge clkb);
      r = rand_bits(20);
      @(posedge clkb);
      rsp_data_b  <= r[19:0];
      rsp_valid_b <= 1'b1;
      rsp_q.push_back(r[19:0]);
      wait_flag(1'b1, W_RSP_RDY, 1'b1, "rsp_ready_b to rise");
      rsp_valid_b <= 1'b0;
      wait_flag(1'b1, W_RSP_RDY, 1'b0, "rsp_ready_b to fall");
    end
  endtask

  // single cycle pulses only while the FIFO has room
  task automatic send_samples(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = rand_bits(3);
      repeat (r[2:0]) @(posedge clka);
      wait_flag(1'b0, W_SMP_RDY, 1'b1, "smp_ready_a to rise");
      r = rand_bits(16);
      smp_data_a  <= r[15:0];
      smp_valid_a <= 1'b1;
      smp_q.push_back(r[15:0]);
      @(posedge clka);
      smp_valid_a <= 1'b0;
    end
  endtask

  // fill the FIFO against a stalled sink and then drain it
  task automatic stall_samples();
    logic [31:0] r;
    int          accepted;
    accepted = 0;
    smp_mode = MODE_HOLD;
    repeat (2) @(posedge clkb);
    @(posedge clka);
    while (smp_ready_a) begin
      if (accepted > 20) begin
        fail_run("smp_ready_a never fell while the sample sink was stalled");
      end
      r = rand_bits(16);
      smp_data_a  <= r[15:0];
      smp_valid_a <= 1'b1;
      smp_q.push_back(r[15:0]);
      accepted++;
      @(posedge clka);
      smp_valid_a <= 1'b0;
      @(posedge clka);  // ready now reflects this write
    end
    if (accepted > 9) begin
      fail_run($sformatf("stalled sample path took %0d words, at most 9 fit", accepted));
    end
    wait_flag(1'b1, W_SMP_VLD, 1'b1, "smp_valid_b to show the stalled word");
    smp_mode = MODE_DRAIN;
    wait_flag(1'b0, W_ALL_DONE, 1'b1, "the stalled samples to drain");
    wait_flag(1'b1, W_SMP_VLD, 1'b0, "smp_valid_b to fall after the drain");
    smp_mode = MODE_RANDOM;
  endtask

  initial begin : cmd_sink
    logic [31:0]       r;
    xdomain_pkg::cmd_t expected;
    cmd_ready_b = 1'b0;
    forever begin
      @(posedge clkb);
      if (cmd_valid_b && cmd_ready_b) begin
        if (cmd_q.size() == 0) begin
          fail_run("command transfer on clkb with no command outstanding");
        end
        expected = cmd_q.pop_front();
        check_value("cmd_data_b", {8'h00, expected}, {8'h00, cmd_data_b});
      end
      r = rand_bits(2);
      cmd_ready_b <= (r[1:0] != 2'b00);  // ready 3 of 4 cycles
    end
  end

  initial begin : rsp_sink
    logic [31:0]       r;
    xdomain_pkg::rsp_t expected;
    rsp_ready_a = 1'b0;
    forever begin
      @(posedge clka);
      if (rsp_valid_a && rsp_ready_a) begin
        if (rsp_q.size() == 0) begin
          fail_run("response transfer on clka with no response outstanding");
        end
        expected = rsp_q.pop_front();
        check_value("rsp_data_a", {12'h000, expected}, {12'h000, rsp_data_a});
      end
      r = rand_bits(1);
      rsp_ready_a <= r[0];
    end
  end

  initial begin : smp_sink
    logic [31:0]                      r;
    logic [xdomain_pkg::SAMPLE_W-1:0] expected;
    logic                             valid_q;  // smp_valid_b at the last edge
    logic                             en_q;     // enable the DUT saw at the last edge
    smp_en_b    = 1'b0;
    smp_ready_b = 1'b0;
    valid_q     = 1'b0;
    en_q        = 1'b0;
    forever begin
      @(posedge clkb);
      if (smp_valid_b && !valid_q && !en_q) begin
        fail_run("smp_valid_b rose although smp_en_b was low");
      end
      if (smp_valid_b && smp_ready_b) begin
        if (smp_q.size() == 0) begin
          fail_run("sample transfer on clkb with no sample outstanding");
        end
        expected = smp_q.pop_front();
        check_value("smp_data_b", {16'h0000, expected}, {16'h0000, smp_data_b});
      end
      valid_q = smp_valid_b;
      en_q    = smp_en_b;
      r = rand_bits(3);
      smp_en_b    <= (smp_mode != MODE_RANDOM) || r[0];
      smp_ready_b <= (smp_mode == MODE_DRAIN) || (smp_mode == MODE_RANDOM && r[2:1] != 2'b00);
    end
  end

  initial begin : main
    arst_n      = 1'b0;
    cmd_data_a  = '0;
    cmd_valid_a = 1'b0;
    rsp_data_b  = '0;
    rsp_valid_b = 1'b0;
    smp_data_a  = '0;
    smp_valid_a = 1'b0;
    repeat (3) @(posedge clka);
    arst_n <= 1'b1;
    repeat (xdomain_pkg::SYNC_DEPTH + 3) @(posedge clkb);
    check_value("cmd_valid_b", 32'd0, {31'd0, cmd_valid_b});  // idle after reset
    check_value("rsp_ready_b", 32'd0, {31'd0, rsp_ready_b});
    check_value("smp_valid_b", 32'd0, {31'd0, smp_valid_b});
    @(posedge clka);
    check_value("rsp_valid_a", 32'd0, {31'd0, rsp_valid_a});
    check_value("cmd_ready_a", 32'd0, {31'd0, cmd_ready_a});
    check_value("smp_ready_a", 32'd1, {31'd0, smp_ready_a});
    send_cmds(200);
    wait_flag(1'b0, W_ALL_DONE, 1'b1, "all commands to arrive on clkb");
    send_rsps(200);
    wait_flag(1'b0, W_ALL_DONE, 1'b1, "all responses to arrive on clka");
    send_samples(200);
    wait_flag(1'b0, W_ALL_DONE, 1'b1, "all samples to arrive on clkb");
    stall_samples();
    fork
      send_cmds(100);
      send_rsps(100);
      send_samples(100);
    join
    wait_flag(1'b0, W_ALL_DONE, 1'b1, "all three channels to drain");
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: sources.f
design/xdomain_pkg.sv
design/reset_sync.sv
design/handshake_stretch.sv
design/async_fifo.sv
design/fifo_xdomain.sv
design/xdomain_bridge.sv
tb/tb_xdomain_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_xdomain_bridge -Mdir obj_dir -f sources.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vtb_xdomain_bridge
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation run ok"
exit 0
